//--- hdl/nibble_rv_pkg.sv
package nibble_rv_pkg;

    // datapath widths
    localparam int XLEN         = 32;
    localparam int NIBBLE_W     = 4;  // one alu slice
    localparam int NIBBLE_COUNT = 8;  // slices per word
    localparam int NIBBLE_IDX_W = 3;

    // 256 words, byte space wraps at 1 KiB
    localparam int MEM_ADDR_W = 8;

    // first fetch after run goes high
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0004;

    // decoded opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 values
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_LW   = 3'b010;

    // ebreak, whole word compare
    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    // core fsm states
    typedef enum logic [2:0] {
        CPU_RESET   = 3'd0, // idle, loader may write ram
        INSTR_FETCH = 3'd1,
        DECODE      = 3'd2,
        EXECUTE     = 3'd3, // sequencer add, for rs1+imm or pc+4
        MEM_READ    = 3'd4,
        WRITEBACK   = 3'd5,
        HALT        = 3'd6, // ebreak seen
        FAULT       = 3'd7  // unsupported instruction
    } cpu_state_e;

endpackage

//--- hdl/nibble_alu.sv
`timescale 1ns/10ps

module nibble_alu (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               step,  // a nibble is being added this cycle
    input  logic                               first, // lowest nibble, no carry in
    input  logic [nibble_rv_pkg::NIBBLE_W-1:0] a,
    input  logic [nibble_rv_pkg::NIBBLE_W-1:0] b,
    output logic [nibble_rv_pkg::NIBBLE_W-1:0] sum
);

    logic carry_q;   // carry out of the previous nibble
    logic carry_in;
    logic carry_out;

    // full adder folded into the slice
    assign carry_in = first ? 1'b0 : carry_q;
    assign {carry_out, sum} = {1'b0, a} + {1'b0, b} + {{nibble_rv_pkg::NIBBLE_W{1'b0}}, carry_in};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            carry_q <= 1'b0;
        end else if (step) begin
            carry_q <= carry_out; // feeds the next nibble
        end
    end

    // the first flag only makes sense on an active step
    a_first_needs_step: assert property (
        @(posedge clk) disable iff (!rst_n) first |-> step
    ) else $error("alu first without step");

endmodule

//--- hdl/nibble_sequencer.sv
`timescale 1ns/10ps

module nibble_sequencer (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [nibble_rv_pkg::XLEN-1:0]     a,
    input  logic [nibble_rv_pkg::XLEN-1:0]     b,
    input  logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_sum,
    output logic                               busy,
    output logic                               done,
    output logic [nibble_rv_pkg::XLEN-1:0]     sum,
    output logic                               alu_step,
    output logic                               alu_first,
    output logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_a,
    output logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_b
);

    logic [nibble_rv_pkg::NIBBLE_IDX_W-1:0] idx_q; // nibble now at the alu
    logic                                   busy_q;
    logic [nibble_rv_pkg::XLEN-1:0]         a_q;   // operands, shifted right per step
    logic [nibble_rv_pkg::XLEN-1:0]         b_q;
    logic [nibble_rv_pkg::XLEN-1:0]         sum_q; // result, filled from the top
    logic                                   last;

    assign last = busy_q && (&idx_q); // nibble 7, index all ones

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (busy_q) begin
            idx_q <= idx_q + 1'b1; // wraps back to 0 after the last nibble
            if (last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // operand and result shifting
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
        end else if (busy_q) begin
            a_q   <= a_q >> nibble_rv_pkg::NIBBLE_W;
            b_q   <= b_q >> nibble_rv_pkg::NIBBLE_W;
            sum_q <= {alu_sum, sum_q[nibble_rv_pkg::XLEN-1:nibble_rv_pkg::NIBBLE_W]};
        end
    end

    assign alu_a     = a_q[nibble_rv_pkg::NIBBLE_W-1:0];
    assign alu_b     = b_q[nibble_rv_pkg::NIBBLE_W-1:0];
    assign alu_step  = busy_q;
    assign alu_first = busy_q && (idx_q == '0); // clears the stored carry

    assign busy = busy_q;
    assign done = last;
    // top nibble comes straight from the alu in the done cycle
    assign sum  = {alu_sum, sum_q[nibble_rv_pkg::XLEN-1:nibble_rv_pkg::NIBBLE_W]};

    // result lands one step per nibble after the request
    a_done_after_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(start, nibble_rv_pkg::NIBBLE_COUNT)
    ) else $error("seq done not eight steps after start");

    // one add in flight
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    ) else $error("seq start while busy");

endmodule

//--- hdl/wb_ram.sv
`timescale 1ns/10ps

module wb_ram (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [nibble_rv_pkg::XLEN-1:0]       wb_adr,   // byte address
    input  logic [nibble_rv_pkg::XLEN-1:0]       wb_dat_w,
    input  logic                                 load_we,  // loader, only while core idle
    input  logic [nibble_rv_pkg::MEM_ADDR_W-1:0] load_addr, // word address
    input  logic [nibble_rv_pkg::XLEN-1:0]       load_data,
    output logic                                 wb_ack,
    output logic [nibble_rv_pkg::XLEN-1:0]       wb_dat_r
);

    logic [nibble_rv_pkg::XLEN-1:0]       mem [2**nibble_rv_pkg::MEM_ADDR_W];
    logic [nibble_rv_pkg::MEM_ADDR_W-1:0] word_idx;
    logic                                 req;
    logic                                 ack_q;

    // byte offset dropped, upper bits wrap
    assign word_idx = wb_adr[nibble_rv_pkg::MEM_ADDR_W+1:2];
    // new request, not the one already acked
    assign req      = wb_cyc && wb_stb && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req; // one cycle pulse
        end
    end

    // array and read data
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end else if (req && wb_we) begin
            mem[word_idx] <= wb_dat_w;
        end
        if (req) begin
            wb_dat_r <= mem[word_idx]; // valid with ack
        end
    end

    assign wb_ack = ack_q;

    // master keeps the strobe up until it sees ack
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb ack outside a bus cycle");

endmodule

//--- hdl/control.sv
`timescale 1ns/10ps

module control (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           wb_ack,
    input  logic [nibble_rv_pkg::XLEN-1:0] wb_dat_r,
    input  logic                           seq_busy,
    input  logic                           seq_done,
    input  logic [nibble_rv_pkg::XLEN-1:0] seq_sum,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [nibble_rv_pkg::XLEN-1:0] wb_adr,
    output logic [nibble_rv_pkg::XLEN-1:0] wb_dat_w,
    output logic                           seq_start,
    output logic [nibble_rv_pkg::XLEN-1:0] seq_a,
    output logic [nibble_rv_pkg::XLEN-1:0] seq_b,
    output logic                           retire_valid,
    output logic [4:0]                     retire_rd,
    output logic [nibble_rv_pkg::XLEN-1:0] retire_value,
    output logic [nibble_rv_pkg::XLEN-1:0] retire_pc,
    output logic                           halted,
    output logic                           fault
);

    nibble_rv_pkg::cpu_state_e state_q;

    logic [nibble_rv_pkg::XLEN-1:0] pc_q;
    logic                           pc_phase_q; // execute is doing pc+4
    logic [nibble_rv_pkg::XLEN-1:0] instr_q;
    logic [nibble_rv_pkg::XLEN-1:0] res_q;      // sum, then load data for lw
    logic [nibble_rv_pkg::XLEN-1:0] rf [32];

    // instruction fields
    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [4:0]                     rd;
    logic [4:0]                     rs1;
    logic [nibble_rv_pkg::XLEN-1:0] imm;
    logic [nibble_rv_pkg::XLEN-1:0] rs1_val;

    assign opcode  = instr_q[6:0];
    assign funct3  = instr_q[14:12];
    assign rd      = instr_q[11:7];
    assign rs1     = instr_q[19:15];
    assign imm     = {{20{instr_q[31]}}, instr_q[31:20]}; // i-type, sign extended
    assign rs1_val = (rs1 == 5'd0) ? '0 : rf[rs1];         // x0 reads zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= nibble_rv_pkg::CPU_RESET;
            pc_q       <= nibble_rv_pkg::RESET_PC;
            pc_phase_q <= 1'b0;
        end else begin
            case (state_q)
                nibble_rv_pkg::CPU_RESET: begin
                    if (run) begin
                        pc_q    <= nibble_rv_pkg::RESET_PC;
                        state_q <= nibble_rv_pkg::INSTR_FETCH;
                    end
                end
                nibble_rv_pkg::INSTR_FETCH: begin
                    if (wb_ack) begin
                        state_q <= nibble_rv_pkg::DECODE;
                    end
                end
                nibble_rv_pkg::DECODE: begin
                    case (opcode)
                        nibble_rv_pkg::OPC_OP_IMM: state_q <= (funct3 == nibble_rv_pkg::F3_ADDI) ?
                            nibble_rv_pkg::EXECUTE : nibble_rv_pkg::FAULT; // only addi
                        nibble_rv_pkg::OPC_LOAD: state_q <= (funct3 == nibble_rv_pkg::F3_LW) ?
                            nibble_rv_pkg::EXECUTE : nibble_rv_pkg::FAULT;  // only lw
                        nibble_rv_pkg::OPC_SYSTEM: state_q <=
                            (instr_q == nibble_rv_pkg::EBREAK_WORD) ?
                            nibble_rv_pkg::HALT : nibble_rv_pkg::FAULT;
                        default: state_q <= nibble_rv_pkg::FAULT;
                    endcase
                end
                nibble_rv_pkg::EXECUTE: begin
                    if (seq_done) begin
                        if (pc_phase_q) begin
                            pc_q       <= seq_sum; // next instruction
                            pc_phase_q <= 1'b0;
                            state_q    <= nibble_rv_pkg::INSTR_FETCH;
                        end else if (opcode == nibble_rv_pkg::OPC_LOAD) begin
                            state_q <= nibble_rv_pkg::MEM_READ;
                        end else begin
                            state_q <= nibble_rv_pkg::WRITEBACK;
                        end
                    end
                end
                nibble_rv_pkg::MEM_READ: begin
                    if (wb_ack) begin
                        state_q <= nibble_rv_pkg::WRITEBACK;
                    end
                end
                nibble_rv_pkg::WRITEBACK: begin
                    pc_phase_q <= 1'b1; // reuse sequencer for pc+4
                    state_q    <= nibble_rv_pkg::EXECUTE;
                end
                default: ; // halt and fault hold until reset
            endcase
        end
    end

    // payload registers and register file
    always_ff @(posedge clk) begin
        if (state_q == nibble_rv_pkg::INSTR_FETCH && wb_ack) begin
            instr_q <= wb_dat_r;
        end
        if (state_q == nibble_rv_pkg::EXECUTE && seq_done && !pc_phase_q) begin
            res_q <= seq_sum; // addi result or lw address
        end else if (state_q == nibble_rv_pkg::MEM_READ && wb_ack) begin
            res_q <= wb_dat_r;
        end
        if (state_q == nibble_rv_pkg::WRITEBACK && rd != 5'd0) begin
            rf[rd] <= res_q;
        end
    end

    // wishbone master, strobe held for the whole fetch or read
    assign wb_stb   = (state_q == nibble_rv_pkg::INSTR_FETCH) ||
                      (state_q == nibble_rv_pkg::MEM_READ);
    assign wb_cyc   = wb_stb;
    assign wb_we    = 1'b0;     // no stores
    assign wb_dat_w = '0;
    assign wb_adr   = (state_q == nibble_rv_pkg::MEM_READ) ?
                      {res_q[nibble_rv_pkg::XLEN-1:2], 2'b00} : pc_q; // word aligned

    // sequencer request, first execute cycle only
    assign seq_start = (state_q == nibble_rv_pkg::EXECUTE) && !seq_busy && !seq_done;
    assign seq_a     = pc_phase_q ? pc_q : rs1_val;
    assign seq_b     = pc_phase_q ? 32'd4 : imm;

    assign retire_valid = (state_q == nibble_rv_pkg::WRITEBACK);
    assign retire_rd    = rd;
    assign retire_value = res_q;
    assign retire_pc    = pc_q; // not yet advanced in write-back
    assign halted       = (state_q == nibble_rv_pkg::HALT);
    assign fault        = (state_q == nibble_rv_pkg::FAULT);

    // request and address stay put until the slave answers
    a_hold_until_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr))
    ) else $error("wb request dropped before ack");

endmodule

//--- hdl/nibble_rv_top.sv
`timescale 1ns/10ps

module nibble_rv_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 run,
    input  logic                                 load_we,
    input  logic [nibble_rv_pkg::MEM_ADDR_W-1:0] load_addr,
    input  logic [nibble_rv_pkg::XLEN-1:0]       load_data,
    output logic                                 retire_valid,
    output logic [4:0]                           retire_rd,
    output logic [nibble_rv_pkg::XLEN-1:0]       retire_value,
    output logic [nibble_rv_pkg::XLEN-1:0]       retire_pc,
    output logic                                 halted,
    output logic                                 fault
);

    // wishbone, core to ram
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [nibble_rv_pkg::XLEN-1:0]     wb_adr;
    logic [nibble_rv_pkg::XLEN-1:0]     wb_dat_w;
    logic                               wb_ack;
    logic [nibble_rv_pkg::XLEN-1:0]     wb_dat_r;

    // sequencer request
    logic                               seq_start;
    logic                               seq_busy;
    logic                               seq_done;
    logic [nibble_rv_pkg::XLEN-1:0]     seq_a;
    logic [nibble_rv_pkg::XLEN-1:0]     seq_b;
    logic [nibble_rv_pkg::XLEN-1:0]     seq_sum;

    // nibble path to the alu
    logic                               alu_step;
    logic                               alu_first;
    logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_a;
    logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_b;
    logic [nibble_rv_pkg::NIBBLE_W-1:0] alu_sum;

    control u_control (
        .clk, .rst_n, .run,
        .wb_ack, .wb_dat_r, .seq_busy, .seq_done, .seq_sum,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .seq_start, .seq_a, .seq_b,
        .retire_valid, .retire_rd, .retire_value, .retire_pc, .halted, .fault
    );

    nibble_sequencer u_seq (
        .clk, .rst_n, .start(seq_start), .a(seq_a), .b(seq_b), .alu_sum,
        .busy(seq_busy), .done(seq_done), .sum(seq_sum),
        .alu_step, .alu_first, .alu_a, .alu_b
    );

    nibble_alu u_alu (
        .clk, .rst_n, .step(alu_step), .first(alu_first),
        .a(alu_a), .b(alu_b), .sum(alu_sum)
    );

    wb_ram u_ram (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .load_we, .load_addr, .load_data, .wb_ack, .wb_dat_r
    );

endmodule

//--- verif/nibble_rv_tb.sv
`timescale 1ns/10ps

module nibble_rv_tb;

    localparam int RUN1_LEN    = 40;  // instructions before ebreak
    localparam int RUN2_LEN    = 12;  // instructions before the bad opcode
    localparam int DATA_BASE   = 64;  // data block, words 64..127
    localparam int DATA_LEN    = 64;
    localparam int HOLD_CYCLES = 40;  // idle watch after halt or fault
    localparam int LOAD_CYCLES = 2 * DATA_LEN + RUN1_LEN + RUN2_LEN + 4;
    localparam int WATCHDOG_CYCLES = (RUN1_LEN + RUN2_LEN + 2) * 30 + LOAD_CYCLES
                                     + 2 * (HOLD_CYCLES + 10) + 200;
    localparam logic [31:0] BAD_WORD = 32'h0000_00b7; // lui, not decoded

    logic                                 clk;
    logic                                 rst_n;
    logic                                 run;
    logic                                 load_we;
    logic [nibble_rv_pkg::MEM_ADDR_W-1:0] load_addr;
    logic [nibble_rv_pkg::XLEN-1:0]       load_data;
    logic                                 retire_valid;
    logic [4:0]                           retire_rd;
    logic [nibble_rv_pkg::XLEN-1:0]       retire_value;
    logic [nibble_rv_pkg::XLEN-1:0]       retire_pc;
    logic                                 halted;
    logic                                 fault;

    int                             seed;
    logic [nibble_rv_pkg::XLEN-1:0] model_rf [32];
    logic [31:0]                    model_valid; // regs with a known value
    logic [nibble_rv_pkg::XLEN-1:0] model_mem [2**nibble_rv_pkg::MEM_ADDR_W];
    logic [nibble_rv_pkg::XLEN-1:0] prog [$];    // words from RESET_PC on
    logic [4:0]                     exp_rd [$];
    logic [nibble_rv_pkg::XLEN-1:0] exp_value [$];
    logic [nibble_rv_pkg::XLEN-1:0] exp_pc [$];

    nibble_rv_top UUT (
        .clk, .rst_n, .run, .load_we, .load_addr, .load_data,
        .retire_valid, .retire_rd, .retire_value, .retire_pc, .halted, .fault
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input logic [nibble_rv_pkg::XLEN-1:0] got,
                              input logic [nibble_rv_pkg::XLEN-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_reg_index(input logic [4:0] got, input logic [4:0] exp,
                                   input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is x%0d, expected x%0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_valid_reg();
        logic [31:0] r;
        r = rand_word();
        while (!model_valid[r[4:0]]) r = rand_word(); // x0 always qualifies
        return r[4:0];
    endfunction

    // builds the program and runs it on the model at the same time
    task automatic gen_program(input int n_instr, input logic [nibble_rv_pkg::XLEN-1:0] last_word);
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] value;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        logic [9:0]  target;
        logic [9:0]  span;
        prog.delete();
        exp_rd.delete();
        exp_value.delete();
        exp_pc.delete();
        model_valid = 32'h1;
        model_rf[0] = '0;
        pc = nibble_rv_pkg::RESET_PC;
        for (int i = 0; i < n_instr; i++) begin
            r   = rand_word();
            rd  = r[4:0];
            rs1 = pick_valid_reg();
            if (i == 1) rd = 5'd0;  // write to x0
            if (i == 2) rs1 = 5'd0; // and read it back
            if (r[7:5] < 3'd3) begin
                target = {2'b01, r[13:8], r[15:14]}; // byte inside the data block
                span   = target - model_rf[rs1][9:0]; // distance mod 1 KiB
                imm    = r[16] ? {2'b00, span} : {2'b11, span}; // same address, neg offset
                addr   = model_rf[rs1] + {{20{imm[11]}}, imm};
                value  = model_mem[addr[nibble_rv_pkg::MEM_ADDR_W+1:2]];
                prog.push_back({imm, rs1, nibble_rv_pkg::F3_LW, rd, nibble_rv_pkg::OPC_LOAD});
            end else begin
                imm = r[19:8];
                if (r[31:30] == 2'b00) imm = r[29] ? 12'hfff : 12'h001; // long carry chains
                value = model_rf[rs1] + {{20{imm[11]}}, imm};
                prog.push_back({imm, rs1, nibble_rv_pkg::F3_ADDI, rd, nibble_rv_pkg::OPC_OP_IMM});
            end
            exp_rd.push_back(rd);
            exp_value.push_back(value);
            exp_pc.push_back(pc);
            if (rd != 5'd0) begin
                model_rf[rd]    = value;
                model_valid[rd] = 1'b1;
            end
            pc = pc + 32'd4;
        end
        prog.push_back(last_word);
    endtask

    task automatic write_word(input logic [nibble_rv_pkg::MEM_ADDR_W-1:0] addr,
                              input logic [nibble_rv_pkg::XLEN-1:0] data);
        @(posedge clk);
        #2;
        load_we   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    // fresh data block plus the program, through the loader port
    task automatic load_image(input int n_instr, input logic [nibble_rv_pkg::XLEN-1:0] last_word);
        logic [31:0] byte_addr;
        for (int w = DATA_BASE; w < DATA_BASE + DATA_LEN; w++) model_mem[w] = rand_word();
        gen_program(n_instr, last_word);
        for (int w = DATA_BASE; w < DATA_BASE + DATA_LEN; w++) begin
            write_word(w[nibble_rv_pkg::MEM_ADDR_W-1:0], model_mem[w]);
        end
        for (int w = 0; w < prog.size(); w++) begin
            byte_addr = nibble_rv_pkg::RESET_PC + w * 4;
            write_word(byte_addr[nibble_rv_pkg::MEM_ADDR_W+1:2], prog[w]);
        end
        @(posedge clk);
        #2;
        load_we = 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        run   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(retire_valid, 1'b0, "retire_valid after reset");
        check_flag(halted, 1'b0, "halted after reset");
        check_flag(fault, 1'b0, "fault after reset");
    endtask

    // in order, one retirement per expected instruction
    task automatic check_retirements();
        for (int k = 0; k < exp_rd.size(); k++) begin
            @(negedge clk);
            while (!retire_valid && !halted && !fault) @(negedge clk);
            if (!retire_valid) begin
                abort_run($sformatf("core stopped before retiring instruction %0d", k));
            end
            check_reg_index(retire_rd, exp_rd[k], $sformatf("rd of instr %0d", k));
            check_word(retire_value, exp_value[k], $sformatf("value of instr %0d", k));
            check_word(retire_pc, exp_pc[k], $sformatf("pc of instr %0d", k));
        end
    endtask

    task automatic check_end(input logic expect_halt);
        @(negedge clk);
        while (!halted && !fault && !retire_valid) @(negedge clk);
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            check_flag(retire_valid, 1'b0, "retire_valid after the last instruction");
            check_flag(halted, expect_halt, "halted");
            check_flag(fault, !expect_halt, "fault");
            @(negedge clk);
        end
    endtask

    initial begin
        seed      = 47584;
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        apply_reset();
        load_image(RUN1_LEN, nibble_rv_pkg::EBREAK_WORD); // run 1 ends in ebreak
        @(posedge clk);
        #2;
        run = 1'b1;
        check_retirements();
        check_end(1'b1);
        apply_reset();
        load_image(RUN2_LEN, BAD_WORD); // run 2 ends on an unsupported opcode
        @(posedge clk);
        #2;
        run = 1'b1;
        check_retirements();
        check_end(1'b0);
        $display("*** PASSED ***");
        $finish;
    end

    initial begin : watchdog
        nibble_rv_pkg::cpu_state_e st;
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        st = UUT.u_control.state_q;
        abort_run($sformatf("timeout: core did not finish within %0d cycles, fsm in %s",
                            WATCHDOG_CYCLES, st.name()));
    end

endmodule

//--- nibble_rv.f
hdl/nibble_rv_pkg.sv
hdl/nibble_alu.sv
hdl/nibble_sequencer.sv
hdl/wb_ram.sv
hdl/control.sv
hdl/nibble_rv_top.sv
verif/nibble_rv_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module nibble_rv_tb \
    -f nibble_rv.f -o nibble_rv_sim \
    && ./obj_dir/nibble_rv_sim \
    || { echo "simulation failed"; exit 1; }
